/* hw/bp_config.svh */
//############################################################################
// fetch predictor sizing
//############################################################################

`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

`define BP_ADDR_BITS   32
`define BP_BTB_ENTRIES 64
`define BP_INDEX_BITS  6            // log2 of BP_BTB_ENTRIES
`define BP_TAG_BITS    10           // pc bits just above the index
`define BP_TARGET_BITS 16           // low target bits kept per entry
`define BP_RESET_PC    32'h0000_1000

`endif

/* hw/resolve_pkg.sv */
//############################################################################
// branch resolve types
//############################################################################

`default_nettype none

`include "bp_config.svh"

package resolve_pkg;

	typedef enum logic {
		br_cond   = 1'b0,
		br_uncond = 1'b1
	} branch_kind_e;

	// one resolved branch as reported by the reorder buffer
	typedef struct packed {
		logic                     valid;      // one cycle strobe
		branch_kind_e             kind;
		logic                     taken;
		logic                     mispredict;
		logic [`BP_ADDR_BITS-1:0] pc;
		logic [`BP_ADDR_BITS-1:0] target;     // correct next pc
	} resolve_t;

endpackage

`default_nettype wire

/* hw/fetch_pkg.sv */
//############################################################################
// fetch side types
//############################################################################

`default_nettype none

`include "bp_config.svh"

package fetch_pkg;
	import resolve_pkg::*;

	typedef struct packed {
		logic                     hit;
		branch_kind_e             kind;
		logic [`BP_ADDR_BITS-1:0] target;     // full predicted target
	} slot_lookup_t;

	typedef struct packed {
		slot_lookup_t slot0;                  // fetch_pc
		slot_lookup_t slot1;                  // fetch_pc + 4
	} slot_pair_t;

	typedef enum logic {
		st_clear = 1'b0,
		st_run   = 1'b1
	} ctrl_state_e;

	// bimodal counter states, high bit is the taken prediction
	typedef enum logic [1:0] {
		cnt_strong_nt = 2'b00,
		cnt_weak_nt   = 2'b01,
		cnt_weak_t    = 2'b10,
		cnt_strong_t  = 2'b11
	} bimodal_e;

endpackage

`default_nettype wire

/* hw/branch_target_buffer.sv */
//############################################################################
// branch target buffer
//############################################################################

`default_nettype none

`include "bp_config.svh"

module branch_target_buffer import fetch_pkg::*, resolve_pkg::*; (
	input  logic                      clock,
	input  logic                      reset,
	input  logic [`BP_ADDR_BITS-1:0]  lookup_pc,
	output slot_pair_t                lookups,
	input  logic                      btb_write,
	input  logic [`BP_ADDR_BITS-1:0]  btb_write_pc,
	input  logic [`BP_ADDR_BITS-1:0]  btb_write_target,
	input  branch_kind_e              btb_write_kind,
	input  logic                      btb_clear,
	input  logic [`BP_INDEX_BITS-1:0] clear_index
);

	// pc field positions, word offset is bits 1:0
	localparam int idx_lo = 2;
	localparam int idx_hi = `BP_INDEX_BITS + 1;
	localparam int tag_lo = idx_hi + 1;
	localparam int tag_hi = tag_lo + `BP_TAG_BITS - 1;
	localparam int tgt_hi = `BP_TARGET_BITS + 1;

	logic                       valid      [`BP_BTB_ENTRIES];
	logic [`BP_TAG_BITS-1:0]    tag_mem    [`BP_BTB_ENTRIES];
	logic [`BP_TARGET_BITS-1:0] target_mem [`BP_BTB_ENTRIES];
	branch_kind_e               kind_mem   [`BP_BTB_ENTRIES];

	logic [`BP_ADDR_BITS-1:0]  slot1_pc;
	logic [`BP_INDEX_BITS-1:0] write_index;

	// tag compare and target rebuild for one slot
	function automatic slot_lookup_t read_slot(input logic [`BP_ADDR_BITS-1:0] pc);
		logic [`BP_INDEX_BITS-1:0] idx;
		slot_lookup_t              res;
		idx = pc[idx_hi:idx_lo];
		res.hit = valid[idx] && (tag_mem[idx] == pc[tag_hi:tag_lo]);
		res.kind = kind_mem[idx];
		// upper bits come from the slot's own pc
		res.target = {pc[`BP_ADDR_BITS-1:tgt_hi+1], target_mem[idx], 2'b00};
		return res;
	endfunction

	assign slot1_pc = lookup_pc + `BP_ADDR_BITS'(4);
	assign write_index = btb_write_pc[idx_hi:idx_lo];

	always_comb begin
		lookups.slot0 = read_slot(lookup_pc);
		lookups.slot1 = read_slot(slot1_pc);
	end

	always_ff @(posedge clock) begin
		if (btb_clear) begin
			valid[clear_index] <= 1'b0;          // sweep after reset
		end
		// a write on the same index lands last and wins
		if (btb_write && !reset) begin
			valid[write_index]      <= 1'b1;
			tag_mem[write_index]    <= btb_write_pc[tag_hi:tag_lo];
			target_mem[write_index] <= btb_write_target[tgt_hi:idx_lo];
			kind_mem[write_index]   <= btb_write_kind;
		end
	end

endmodule

`default_nettype wire

/* hw/bimodal_counter_table.sv */
//############################################################################
// bimodal counter table
//############################################################################

`default_nettype none

`include "bp_config.svh"

module bimodal_counter_table import fetch_pkg::*; (
	input  logic                      clock,
	input  logic                      reset,
	input  logic [`BP_ADDR_BITS-1:0]  lookup_pc,
	output logic                      slot0_taken,
	output logic                      slot1_taken,
	input  logic                      cnt_train,
	input  logic [`BP_ADDR_BITS-1:0]  cnt_train_pc,
	input  logic                      cnt_train_taken,
	input  logic                      btb_clear,
	input  logic [`BP_INDEX_BITS-1:0] clear_index
);

	localparam int idx_hi = `BP_INDEX_BITS + 1;

	bimodal_e cnt_mem [`BP_BTB_ENTRIES];

	logic [`BP_ADDR_BITS-1:0]  slot1_pc;
	logic [`BP_INDEX_BITS-1:0] train_index;
	bimodal_e                  trained;

	assign slot1_pc = lookup_pc + `BP_ADDR_BITS'(4);
	assign train_index = cnt_train_pc[idx_hi:2];

	assign slot0_taken = cnt_mem[lookup_pc[idx_hi:2]][1];
	assign slot1_taken = cnt_mem[slot1_pc[idx_hi:2]][1];

	// saturating step, stays put at either end
	always_comb begin
		case (cnt_mem[train_index])
			cnt_strong_nt: trained = cnt_train_taken ? cnt_weak_nt : cnt_strong_nt;
			cnt_weak_nt:   trained = cnt_train_taken ? cnt_weak_t : cnt_strong_nt;
			cnt_weak_t:    trained = cnt_train_taken ? cnt_strong_t : cnt_weak_nt;
			default:       trained = cnt_train_taken ? cnt_strong_t : cnt_weak_t;
		endcase
	end

	always_ff @(posedge clock) begin
		if (btb_clear) begin
			cnt_mem[clear_index] <= cnt_weak_nt;
		end
		if (cnt_train && !reset) begin
			cnt_mem[train_index] <= trained;
		end
	end

endmodule

`default_nettype wire

/* hw/fetch_predict_ctrl.sv */
//############################################################################
// next fetch address control
//############################################################################

`default_nettype none

`include "bp_config.svh"

module fetch_predict_ctrl import fetch_pkg::*, resolve_pkg::*; (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      stall,
	input  resolve_t                  resolve,
	input  slot_pair_t                lookups,
	input  logic                      slot0_taken,
	input  logic                      slot1_taken,
	output logic [`BP_ADDR_BITS-1:0]  fetch_pc,
	output logic                      fetch_valid,
	output logic                      btb_write,
	output logic [`BP_ADDR_BITS-1:0]  btb_write_pc,
	output logic [`BP_ADDR_BITS-1:0]  btb_write_target,
	output branch_kind_e              btb_write_kind,
	output logic                      btb_clear,
	output logic [`BP_INDEX_BITS-1:0] clear_index,
	output logic                      cnt_train,
	output logic [`BP_ADDR_BITS-1:0]  cnt_train_pc,
	output logic                      cnt_train_taken
);

	localparam int unsigned last_entry = `BP_BTB_ENTRIES - 1;

	ctrl_state_e               state;
	logic [`BP_INDEX_BITS-1:0] clear_count;
	logic [`BP_ADDR_BITS-1:0]  next_pc;
	logic                      in_run;
	logic                      resolve_ok;   // resolve seen while running
	logic                      slot0_take;
	logic                      slot1_take;

	assign in_run = (state == st_run);
	assign resolve_ok = in_run && resolve.valid;

	// unconditional always goes, conditional asks the counter
	assign slot0_take = lookups.slot0.hit && (lookups.slot0.kind == br_uncond || slot0_taken);
	assign slot1_take = lookups.slot1.hit && (lookups.slot1.kind == br_uncond || slot1_taken);

	always_comb begin
		if (resolve_ok && resolve.mispredict) begin
			next_pc = {resolve.target[`BP_ADDR_BITS-1:2], 2'b00};   // redirect beats stall
		end else if (stall) begin
			next_pc = fetch_pc;
		end else if (slot0_take) begin
			next_pc = lookups.slot0.target;
		end else if (slot1_take) begin
			next_pc = lookups.slot1.target;
		end else begin
			next_pc = fetch_pc + `BP_ADDR_BITS'(8);               // sequential two wide
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= st_clear;
			clear_count <= '0;
			fetch_pc    <= `BP_RESET_PC;
		end else begin
			case (state)
				st_clear: begin
					clear_count <= clear_count + 1'b1;
					if (clear_count == last_entry[`BP_INDEX_BITS-1:0]) begin
						state    <= st_run;
						fetch_pc <= `BP_RESET_PC;
					end
				end
				default: fetch_pc <= next_pc;
			endcase
		end
	end

	assign fetch_valid = in_run;

	// sweep one entry of each table per cycle
	assign btb_clear   = (state == st_clear);
	assign clear_index = clear_count;

	// only taken branches earn a buffer entry
	assign btb_write        = resolve_ok && resolve.taken;
	assign btb_write_pc     = resolve.pc;
	assign btb_write_target = resolve.target;
	assign btb_write_kind   = resolve.kind;

	assign cnt_train       = resolve_ok && (resolve.kind == br_cond);
	assign cnt_train_pc    = resolve.pc;
	assign cnt_train_taken = resolve.taken;

endmodule

`default_nettype wire

/* hw/fetch_predictor_top.sv */
//############################################################################
// fetch predictor top
//############################################################################

`default_nettype none

`include "bp_config.svh"

module fetch_predictor_top import fetch_pkg::*, resolve_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     stall,
	input  resolve_t                 resolve,
	output logic [`BP_ADDR_BITS-1:0] fetch_pc,
	output logic                     fetch_valid
);

	slot_pair_t                lookups;
	logic                      slot0_taken;
	logic                      slot1_taken;
	logic                      btb_write;
	logic [`BP_ADDR_BITS-1:0]  btb_write_pc;
	logic [`BP_ADDR_BITS-1:0]  btb_write_target;
	branch_kind_e              btb_write_kind;
	logic                      btb_clear;
	logic [`BP_INDEX_BITS-1:0] clear_index;
	logic                      cnt_train;
	logic [`BP_ADDR_BITS-1:0]  cnt_train_pc;
	logic                      cnt_train_taken;

	fetch_predict_ctrl u_ctrl (
		.clock, .reset, .stall, .resolve, .lookups, .slot0_taken, .slot1_taken,
		.fetch_pc, .fetch_valid, .btb_write, .btb_write_pc, .btb_write_target,
		.btb_write_kind, .btb_clear, .clear_index, .cnt_train, .cnt_train_pc,
		.cnt_train_taken
	);

	branch_target_buffer u_btb (
		.clock, .reset, .lookup_pc(fetch_pc), .lookups, .btb_write, .btb_write_pc,
		.btb_write_target, .btb_write_kind, .btb_clear, .clear_index
	);

	bimodal_counter_table u_counters (
		.clock, .reset, .lookup_pc(fetch_pc), .slot0_taken, .slot1_taken,
		.cnt_train, .cnt_train_pc, .cnt_train_taken, .btb_clear, .clear_index
	);

endmodule

`default_nettype wire

/* testbench/fetch_predictor_chk.sv */
//############################################################################
// fetch control assertions
//############################################################################

`default_nettype none

`include "bp_config.svh"

module fetch_predictor_chk (
	input logic                     clock,
	input logic                     reset,
	input logic                     fetch_valid,
	input logic                     btb_write,
	input logic                     cnt_train,
	input logic [`BP_ADDR_BITS-1:0] fetch_pc
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned since_reset;    // edges since reset fell, stops at the table size

	always_ff @(posedge clock) begin
		if (reset) begin
			since_reset <= 0;
		end else if (since_reset < `BP_BTB_ENTRIES) begin
			since_reset <= since_reset + 1;
		end
	end

	// fetch stays quiet while the tables are swept
	quiet_in_clear: assert property (@(posedge clock) disable iff (reset)
		since_reset < `BP_BTB_ENTRIES |-> !fetch_valid)
		else $error("fetch_valid high during clear");

	no_write_in_clear: assert property (@(posedge clock) disable iff (reset)
		since_reset < `BP_BTB_ENTRIES |-> !btb_write && !cnt_train)
		else $error("table write strobe high during clear");

	word_aligned: assert property (@(posedge clock) disable iff (reset)
		fetch_pc[1:0] == 2'b00)   // instructions are whole words
		else $error("fetch_pc not word aligned");

endmodule

`default_nettype wire

/* testbench/fetch_predictor_monitor.sv */
//############################################################################
// fetch address monitor
//############################################################################

`default_nettype none

`include "bp_config.svh"

module fetch_predictor_monitor (
	input  logic                     clock,
	input  logic                     reset,
	input  logic [`BP_ADDR_BITS-1:0] fetch_pc,
	input  logic                     fetch_valid,
	input  logic                     exp_valid,
	input  logic [`BP_ADDR_BITS-1:0] exp_pc,
	output int                       error_count,
	output int                       check_count
);
	timeunit 1ns;
	timeprecision 1ps;

	logic                     pending;
	logic [`BP_ADDR_BITS-1:0] pending_pc;

	// an expectation given with a step holds after the following edge
	always @(posedge clock) begin
		pending    <= exp_valid && !reset;
		pending_pc <= exp_pc;
	end

	always @(negedge clock) begin
		if (reset) begin
			error_count = 0;
			check_count = 0;
		end else if (pending) begin
			check_count++;
			if (fetch_valid !== 1'b1) begin
				$display("[ERROR] check %0d fetch_valid got %h expected 1", check_count,
					fetch_valid);
				error_count++;
			end
			if (fetch_pc !== pending_pc) begin
				$display("[ERROR] check %0d fetch_pc got %h expected %h", check_count,
					fetch_pc, pending_pc);
				error_count++;
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/fetch_predictor_tb.sv */
//############################################################################
// fetch predictor testbench
//############################################################################

`default_nettype none

`include "bp_config.svh"

module fetch_predictor_tb import resolve_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic                     clock;
	logic                     reset;
	logic                     stall;
	resolve_t                 resolve;
	logic [`BP_ADDR_BITS-1:0] fetch_pc;
	logic                     fetch_valid;
	logic                     exp_valid;
	logic [`BP_ADDR_BITS-1:0] exp_pc;
	int                       value_errors;
	int                       checks_done;
	int                       other_errors;

	fetch_predictor_top u_dut (.clock, .reset, .stall, .resolve, .fetch_pc, .fetch_valid);

	fetch_predictor_monitor u_monitor (.clock, .reset, .fetch_pc, .fetch_valid, .exp_valid,
		.exp_pc, .error_count(value_errors), .check_count(checks_done));

	bind fetch_predict_ctrl fetch_predictor_chk u_chk (.clock, .reset, .fetch_valid,
		.btb_write, .cnt_train, .fetch_pc);

	always #10 clock = ~clock;

	// columns: stall valid kind taken mispredict pc target expected
	task automatic apply_vectors();
		int          fd;
		int          line_no;
		string       line;
		logic [31:0] f [8];
		fd = $fopen("testbench/fetch_predictor_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vectors file");
			other_errors++;
			return;
		end
		line_no = 0;
		while ($fgets(line, fd) != 0) begin
			line_no++;
			if (line.len() < 2 || line[0] == "#") continue;
			if ($sscanf(line, "%h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5],
				f[6], f[7]) != 8) begin
				$display("vectors line %0d could not be parsed", line_no);
				other_errors++;
				continue;
			end
			@(posedge clock);
			stall              <= f[0][0];
			resolve.valid      <= f[1][0];
			resolve.kind       <= branch_kind_e'(f[2][0]);
			resolve.taken      <= f[3][0];
			resolve.mispredict <= f[4][0];
			resolve.pc         <= f[5];
			resolve.target     <= f[6] | `BP_ADDR_BITS'(2);   // odd offset, DUT drops it
			exp_valid          <= 1'b1;
			exp_pc             <= f[7];      // fetch_pc after the next edge
		end
		$fclose(fd);
		@(posedge clock);
		stall     <= 1'b1;
		resolve   <= '0;
		exp_valid <= 1'b0;
		@(posedge clock);
		@(negedge clock);                  // last check has been made
	endtask

	initial begin : main
		int cycles;
		clock = 1'b0;
		reset = 1'b1;
		stall = 1'b1;                      // hold the reset pc until vectors start
		resolve = '0;
		exp_valid = 1'b0;
		exp_pc = '0;
		other_errors = 0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		// a resolve during the sweep must leave no trace in the tables
		@(posedge clock);
		resolve.valid      <= 1'b1;
		resolve.kind       <= br_uncond;
		resolve.taken      <= 1'b1;
		resolve.mispredict <= 1'b1;
		resolve.pc         <= `BP_RESET_PC;     // slot 0 of the first fetch
		resolve.target     <= 32'h0000_7000;
		@(posedge clock);
		resolve <= '0;
		cycles = 0;
		while (fetch_valid !== 1'b1 && cycles < `BP_BTB_ENTRIES + 20) begin
			@(negedge clock);
			cycles++;
		end
		if (fetch_valid === 1'b1) begin
			apply_vectors();
		end else begin
			$display("fetch never started after the table clear");
			other_errors++;
		end
		$display("checks %0d, value errors %0d, other errors %0d", checks_done, value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0 && checks_done > 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/resolve_pkg.sv
hw/fetch_pkg.sv
hw/branch_target_buffer.sv
hw/bimodal_counter_table.sv
hw/fetch_predict_ctrl.sv
hw/fetch_predictor_top.sv
testbench/fetch_predictor_chk.sv
testbench/fetch_predictor_monitor.sv
testbench/fetch_predictor_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch predictor simulation with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
	--top-module fetch_predictor_tb -Mdir obj_dir -o fetch_predictor_sim; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/fetch_predictor_sim > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error status"
	exit 1
fi
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
	exit 0
fi
exit 1

/* testbench/fetch_predictor_vectors.txt */
# hex columns: stall valid kind(1=uncond) taken mispredict pc target expected_fetch_pc
1 0 0 0 0 00000000 00000000 00001000
0 0 0 0 0 00000000 00000000 00001008
0 0 0 0 0 00000000 00000000 00001010
1 0 0 0 0 00000000 00000000 00001010
1 1 1 1 1 00001100 00002000 00002000
0 0 0 0 0 00000000 00000000 00002008
0 1 1 1 1 00002008 00001100 00001100
0 0 0 0 0 00000000 00000000 00002000
0 1 1 1 1 00003030 000010fc 000010fc
0 0 0 0 0 00000000 00000000 00002000
0 1 1 1 1 00001104 00004000 00004000
0 1 1 1 1 00003030 00001100 00001100
0 0 0 0 0 00000000 00000000 00002000
0 1 0 1 1 00002010 00002400 00002400
0 1 1 1 1 00003030 00002010 00002010
0 0 0 0 0 00000000 00000000 00002400
1 1 0 0 0 00002010 00002014 00002400
1 1 0 0 0 00002010 00002014 00002400
0 1 1 1 1 00003030 00002010 00002010
0 0 0 0 0 00000000 00000000 00002018
0 1 1 1 1 00002100 00005000 00005000
0 1 1 1 1 00003030 000010fc 000010fc
0 0 0 0 0 00000000 00000000 00001104
